//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module conv_tb -Mdir obj_dir
	out=$$(./obj_dir/Vconv_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

//--- common/conv_pkg.sv
package conv_pkg;

  // kernel side, at least 4 so a result is ready by the next write slot
  localparam int KERNEL_DEF = 5;
  localparam int FRAC_BITS  = 8;
  localparam int ADDR_W_DEF = 16;

  typedef logic signed [15:0] pixel_t;

  // one memory word, ch0 in the upper half
  typedef struct packed {
    pixel_t ch0;
    pixel_t ch1;
  } pair_t;

  typedef logic signed [31:0] prod_t;
  typedef logic signed [31:0] acc_t;

  localparam pixel_t PIX_MAX = 16'sh7fff;
  localparam pixel_t PIX_MIN = 16'sh8000;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LOAD_COEF = 3'd1,
    FILL      = 3'd2,
    STEP      = 3'd3,
    COMPUTE   = 3'd4,
    DRAIN     = 3'd5,
    DONE      = 3'd6
  } conv_state_t;

endpackage

//--- flist.f
+incdir+tb
common/conv_pkg.sv
hw/conv_engine/tap_shift.sv
hw/conv_engine/mac_tree.sv
hw/conv_engine/bias_add.sv
hw/conv_ctrl.sv
hw/conv_counters.sv
hw/conv_mem_port.sv
hw/conv_top.sv
tb/conv_tb.sv

//--- hw/conv_counters.sv
`timescale 1ns/1ps

module conv_counters #(
  parameter int IMG_W  = 12,
  parameter int IMG_H  = 8,
  parameter int KERNEL = conv_pkg::KERNEL_DEF,
  parameter int ADDR_W = conv_pkg::ADDR_W_DEF
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  conv_pkg::conv_state_t                  state,
  output logic [$clog2(KERNEL+1)-1:0]            tap_cnt,
  output logic [$clog2(2*KERNEL*KERNEL+1)-1:0]   coef_cnt,
  output logic [ADDR_W-1:0]                      col_base,
  output logic                                   tap_last,
  output logic                                   fill_last,
  output logic                                   coef_last,
  output logic                                   row_last,
  output logic                                   frame_last
);
  import conv_pkg::*;

  localparam int OUT_W = IMG_W - KERNEL + 1;
  localparam int OUT_H = IMG_H - KERNEL + 1;
  localparam int NCOEF = 2 * KERNEL * KERNEL;

  logic [$clog2(KERNEL)-1:0]  fill_col;
  logic [$clog2(OUT_W+1)-1:0] ox;
  logic [$clog2(OUT_H+1)-1:0] oy;
  logic [ADDR_W-1:0]          row_base;
  logic                       in_slot;

  assign in_slot    = (state == FILL) || (state == STEP) || (state == DRAIN);
  assign tap_last   = (tap_cnt == KERNEL);
  assign coef_last  = (coef_cnt == NCOEF);
  assign fill_last  = (fill_col == KERNEL - 2);
  assign row_last   = (ox == OUT_W - 1);
  assign frame_last = row_last && (oy == OUT_H - 1);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tap_cnt  <= '0;
      coef_cnt <= '0;
      fill_col <= '0;
    end else begin
      if (in_slot && !tap_last) begin
        tap_cnt <= tap_cnt + 1'b1;
      end else begin
        tap_cnt <= '0;
      end
      if (state == LOAD_COEF) begin
        coef_cnt <= coef_cnt + 1'b1;
      end else if (state == IDLE) begin
        coef_cnt <= '0;
      end
      if (state != FILL) begin
        fill_col <= '0;
      end else if (tap_last) begin
        fill_col <= fill_col + 1'b1;
      end
    end
  end

  // output position and column addresses
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ox       <= '0;
      oy       <= '0;
      row_base <= '0;
      col_base <= '0;
    end else if (state == IDLE) begin
      ox       <= '0;
      oy       <= '0;
      row_base <= '0;
      col_base <= '0;
    end else if (state == COMPUTE) begin
      if (row_last) begin
        ox       <= '0;
        oy       <= oy + 1'b1;
        row_base <= row_base + ADDR_W'(IMG_W);
        col_base <= row_base + ADDR_W'(IMG_W);
      end else begin
        ox <= ox + 1'b1;
      end
    end else if (in_slot && tap_last) begin
      col_base <= col_base + 1'b1;
    end
  end

endmodule

//--- hw/conv_ctrl.sv
`timescale 1ns/1ps

module conv_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  tap_last,
  input  logic                  fill_last,
  input  logic                  coef_last,
  input  logic                  row_last,
  input  logic                  frame_last,
  output conv_pkg::conv_state_t state,
  output logic                  compute,
  output logic                  done
);
  import conv_pkg::*;

  conv_state_t state_nx;

  always_comb begin
    state_nx = state;
    case (state)
      IDLE: begin
        if (start) begin
          state_nx = LOAD_COEF;
        end
      end
      LOAD_COEF: begin
        // last read of the load is the bias word
        if (coef_last) begin
          state_nx = FILL;
        end
      end
      FILL: begin
        if (tap_last && fill_last) begin
          state_nx = STEP;
        end
      end
      STEP: begin
        if (tap_last) begin
          state_nx = COMPUTE;
        end
      end
      COMPUTE: begin
        if (frame_last) begin
          state_nx = DRAIN;
        end else if (row_last) begin
          state_nx = FILL;
        end else begin
          state_nx = STEP;
        end
      end
      DRAIN: begin
        // one slot so the last pending result reaches memory
        if (tap_last) begin
          state_nx = DONE;
        end
      end
      DONE: begin
        state_nx = IDLE;
      end
      default: begin
        state_nx = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nx;
    end
  end

  // window is complete in COMPUTE, the last column landed in the write slot
  assign compute = (state == COMPUTE);
  assign done    = (state == DONE);

endmodule

//--- hw/conv_engine/bias_add.sv
`timescale 1ns/1ps

module bias_add (
  input  logic            clk,
  input  logic            rst,
  input  logic            bias_load,
  input  logic            sum_valid,
  input  conv_pkg::pair_t bias_word,
  input  conv_pkg::pair_t sum,
  output logic            out_valid,
  output conv_pkg::pair_t out_data
);
  import conv_pkg::*;

  pair_t bias_q;

  function automatic pixel_t sat_add(pixel_t a, pixel_t b);
    logic signed [16:0] s;
    s = a + b;
    // top two bits disagree on overflow
    if (s[16] != s[15]) begin
      return s[16] ? PIX_MIN : PIX_MAX;
    end
    return pixel_t'(s[15:0]);
  endfunction

  always_ff @(posedge clk) begin
    if (bias_load) begin
      bias_q <= bias_word;
    end
    if (sum_valid) begin
      out_data.ch0 <= sat_add(sum.ch0, bias_q.ch0);
      out_data.ch1 <= sat_add(sum.ch1, bias_q.ch1);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= sum_valid;
    end
  end

endmodule

//--- hw/conv_engine/mac_tree.sv
`timescale 1ns/1ps

module mac_tree #(
  parameter int KERNEL = conv_pkg::KERNEL_DEF
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            compute,
  input  conv_pkg::pair_t win [KERNEL*KERNEL],
  input  conv_pkg::pair_t wa  [KERNEL*KERNEL],
  input  conv_pkg::pair_t wb  [KERNEL*KERNEL],
  output logic            sum_valid,
  output conv_pkg::pair_t sum
);
  import conv_pkg::*;

  localparam int NTAP = KERNEL * KERNEL;

  // indexed [pass][channel]
  prod_t prod  [2][2][NTAP];
  acc_t  row_d [2][2][KERNEL];
  acc_t  row_q [2][2][KERNEL];
  acc_t  total [2];
  logic  v1;
  logic  v2;

  function automatic pixel_t rescale(acc_t a);
    logic [16-FRAC_BITS:0] hi;
    hi = a[31:FRAC_BITS+15];
    if ((hi == '0) || (hi == '1)) begin
      return pixel_t'(a[FRAC_BITS+15:FRAC_BITS]);
    end
    return a[31] ? PIX_MIN : PIX_MAX;
  endfunction

  always_ff @(posedge clk) begin
    if (compute) begin
      for (int t = 0; t < NTAP; t++) begin
        prod[0][0][t] <= win[t].ch0 * wa[t].ch0;
        prod[0][1][t] <= win[t].ch1 * wa[t].ch1;
        prod[1][0][t] <= win[t].ch0 * wb[t].ch0;
        prod[1][1][t] <= win[t].ch1 * wb[t].ch1;
      end
    end
  end

  // tap t = c*KERNEL + r, so kernel row r strides by KERNEL
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      for (int ch = 0; ch < 2; ch++) begin
        for (int r = 0; r < KERNEL; r++) begin
          row_d[p][ch][r] = '0;
          for (int c = 0; c < KERNEL; c++) begin
            row_d[p][ch][r] += prod[p][ch][c*KERNEL + r];
          end
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < 2; p++) begin
      total[p] = '0;
      for (int r = 0; r < KERNEL; r++) begin
        total[p] += row_q[p][0][r] + row_q[p][1][r];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (v1) begin
      row_q <= row_d;
    end
    if (v2) begin
      sum.ch0 <= rescale(total[0]);
      sum.ch1 <= rescale(total[1]);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      v1        <= 1'b0;
      v2        <= 1'b0;
      sum_valid <= 1'b0;
    end else begin
      v1        <= compute;
      v2        <= v1;
      sum_valid <= v2;
    end
  end

endmodule

//--- hw/conv_engine/tap_shift.sv
`timescale 1ns/1ps

module tap_shift #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 25
) (
  input  logic clk,
  input  logic rst,
  input  logic shift,
  input  T     din,
  output T     taps [DEPTH]
);

  // newest entry at the top, oldest drifts down to index 0
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        taps[i] <= T'('0);
      end
    end else if (shift) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        taps[i] <= taps[i+1];
      end
      taps[DEPTH-1] <= din;
    end
  end

endmodule

//--- hw/conv_mem_port.sv
`timescale 1ns/1ps

module conv_mem_port #(
  parameter int IMG_W    = 12,
  parameter int KERNEL   = conv_pkg::KERNEL_DEF,
  parameter int ADDR_W   = conv_pkg::ADDR_W_DEF,
  parameter int W_BASE   = 'h0100,
  parameter int B_BASE   = 'h0140,
  parameter int OUT_BASE = 'h0200
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  conv_pkg::conv_state_t                state,
  input  logic [$clog2(KERNEL+1)-1:0]          tap_cnt,
  input  logic [$clog2(2*KERNEL*KERNEL+1)-1:0] coef_cnt,
  input  logic [ADDR_W-1:0]                    col_base,
  input  logic                                 out_valid,
  input  conv_pkg::pair_t                      out_data,
  output logic [ADDR_W-1:0]                    mem_addr,
  output logic                                 mem_wen,
  output conv_pkg::pair_t                      mem_wdata,
  output logic                                 win_shift,
  output logic                                 wa_shift,
  output logic                                 wb_shift,
  output logic                                 bias_load
);
  import conv_pkg::*;

  localparam int NTAP = KERNEL * KERNEL;

  logic [ADDR_W-1:0] wr_addr;
  logic              pend_valid;
  logic              win_slot;
  logic              write_slot;
  logic              in_load;

  assign in_load    = (state == LOAD_COEF);
  assign win_slot   = ((state == FILL) || (state == STEP)) && (tap_cnt < KERNEL);
  // tap KERNEL of every slot, DRAIN included
  assign write_slot = ((state == FILL) || (state == STEP) || (state == DRAIN))
                      && (tap_cnt == KERNEL);
  assign mem_wen    = pend_valid && write_slot;

  always_comb begin
    if (in_load) begin
      if (coef_cnt < 2 * NTAP) begin
        mem_addr = ADDR_W'(W_BASE) + ADDR_W'(coef_cnt);
      end else begin
        mem_addr = ADDR_W'(B_BASE);
      end
    end else if (mem_wen) begin
      mem_addr = wr_addr;
    end else begin
      mem_addr = col_base + ADDR_W'(tap_cnt) * ADDR_W'(IMG_W);
    end
  end

  // tags follow the read by one cycle to meet the data
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      win_shift <= 1'b0;
      wa_shift  <= 1'b0;
      wb_shift  <= 1'b0;
      bias_load <= 1'b0;
    end else begin
      win_shift <= win_slot;
      wa_shift  <= in_load && (coef_cnt < NTAP);
      wb_shift  <= in_load && (coef_cnt >= NTAP) && (coef_cnt < 2 * NTAP);
      bias_load <= in_load && (coef_cnt == 2 * NTAP);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pend_valid <= 1'b0;
      wr_addr    <= ADDR_W'(OUT_BASE);
    end else begin
      if (out_valid) begin
        pend_valid <= 1'b1;
      end else if (mem_wen) begin
        pend_valid <= 1'b0;
      end
      if (state == IDLE) begin
        wr_addr <= ADDR_W'(OUT_BASE);
      end else if (mem_wen) begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_valid) begin
      mem_wdata <= out_data;
    end
  end

endmodule

//--- hw/conv_top.sv
`timescale 1ns/1ps

module conv_top #(
  parameter int IMG_W    = 12,
  parameter int IMG_H    = 8,
  parameter int KERNEL   = conv_pkg::KERNEL_DEF,
  parameter int ADDR_W   = conv_pkg::ADDR_W_DEF,
  parameter int W_BASE   = 'h0100,
  parameter int B_BASE   = 'h0140,
  parameter int OUT_BASE = 'h0200
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  conv_pkg::pair_t   mem_rdata,
  output logic [ADDR_W-1:0] mem_addr,
  output logic              mem_wen,
  output conv_pkg::pair_t   mem_wdata,
  output logic              done
);
  import conv_pkg::*;

  localparam int NTAP   = KERNEL * KERNEL;
  localparam int TAP_W  = $clog2(KERNEL + 1);
  localparam int COEF_W = $clog2(2 * NTAP + 1);

  conv_state_t       state;
  logic              compute;
  logic [TAP_W-1:0]  tap_cnt;
  logic [COEF_W-1:0] coef_cnt;
  logic [ADDR_W-1:0] col_base;
  logic              tap_last;
  logic              fill_last;
  logic              coef_last;
  logic              row_last;
  logic              frame_last;
  logic              win_shift;
  logic              wa_shift;
  logic              wb_shift;
  logic              bias_load;
  logic              sum_valid;
  logic              out_valid;
  pair_t             sum;
  pair_t             out_data;
  pair_t             win_taps [NTAP];
  pair_t             wa_taps  [NTAP];
  pair_t             wb_taps  [NTAP];

  conv_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .tap_last   (tap_last),
    .fill_last  (fill_last),
    .coef_last  (coef_last),
    .row_last   (row_last),
    .frame_last (frame_last),
    .state      (state),
    .compute    (compute),
    .done       (done)
  );

  conv_counters #(
    .IMG_W  (IMG_W),
    .IMG_H  (IMG_H),
    .KERNEL (KERNEL),
    .ADDR_W (ADDR_W)
  ) u_counters (
    .clk        (clk),
    .rst        (rst),
    .state      (state),
    .tap_cnt    (tap_cnt),
    .coef_cnt   (coef_cnt),
    .col_base   (col_base),
    .tap_last   (tap_last),
    .fill_last  (fill_last),
    .coef_last  (coef_last),
    .row_last   (row_last),
    .frame_last (frame_last)
  );

  conv_mem_port #(
    .IMG_W    (IMG_W),
    .KERNEL   (KERNEL),
    .ADDR_W   (ADDR_W),
    .W_BASE   (W_BASE),
    .B_BASE   (B_BASE),
    .OUT_BASE (OUT_BASE)
  ) u_mem_port (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .tap_cnt   (tap_cnt),
    .coef_cnt  (coef_cnt),
    .col_base  (col_base),
    .out_valid (out_valid),
    .out_data  (out_data),
    .mem_addr  (mem_addr),
    .mem_wen   (mem_wen),
    .mem_wdata (mem_wdata),
    .win_shift (win_shift),
    .wa_shift  (wa_shift),
    .wb_shift  (wb_shift),
    .bias_load (bias_load)
  );

  // pixel-pair window
  tap_shift #(.T(pair_t), .DEPTH(NTAP)) u_win (
    .clk   (clk),
    .rst   (rst),
    .shift (win_shift),
    .din   (mem_rdata),
    .taps  (win_taps)
  );

  // pass A weights, output 0
  tap_shift #(.T(pair_t), .DEPTH(NTAP)) u_wa (
    .clk   (clk),
    .rst   (rst),
    .shift (wa_shift),
    .din   (mem_rdata),
    .taps  (wa_taps)
  );

  // pass B weights, output 1
  tap_shift #(.T(pair_t), .DEPTH(NTAP)) u_wb (
    .clk   (clk),
    .rst   (rst),
    .shift (wb_shift),
    .din   (mem_rdata),
    .taps  (wb_taps)
  );

  mac_tree #(.KERNEL(KERNEL)) u_mac (
    .clk       (clk),
    .rst       (rst),
    .compute   (compute),
    .win       (win_taps),
    .wa        (wa_taps),
    .wb        (wb_taps),
    .sum_valid (sum_valid),
    .sum       (sum)
  );

  bias_add u_bias (
    .clk       (clk),
    .rst       (rst),
    .bias_load (bias_load),
    .sum_valid (sum_valid),
    .bias_word (mem_rdata),
    .sum       (sum),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

endmodule

//--- tb/conv_ref_model.svh
`ifndef CONV_REF_MODEL_SVH
`define CONV_REF_MODEL_SVH

// expects ref_mem and the layer geometry from the including module

// clamp a wide signed value to the 16-bit pixel range
function automatic logic [15:0] clamp16(longint v);
  if (v > 32767) begin
    return 16'h7fff;
  end
  if (v < -32768) begin
    return 16'h8000;
  end
  return v[15:0];
endfunction

// both channels over one window for one weight pass, wrapped to 32 bits
function automatic int window_sum(int ox, int oy, int pass);
  int                 acc;
  logic [31:0]        px;
  logic [31:0]        wt;
  logic signed [15:0] p0;
  logic signed [15:0] p1;
  logic signed [15:0] w0;
  logic signed [15:0] w1;
  acc = 0;
  for (int c = 0; c < KERNEL; c++) begin
    for (int r = 0; r < KERNEL; r++) begin
      px  = ref_mem[(oy + r) * IMG_W + ox + c];
      wt  = ref_mem[W_BASE + pass * NTAP + c * KERNEL + r];
      p0  = px[31:16];
      p1  = px[15:0];
      w0  = wt[31:16];
      w1  = wt[15:0];
      acc += int'(p0) * int'(w0);
      acc += int'(p1) * int'(w1);
    end
  end
  return acc;
endfunction

// rescale with saturation, then the saturating bias add
function automatic logic [15:0] output_half(int acc, logic [15:0] bias);
  logic signed [15:0] scaled;
  logic signed [15:0] b;
  scaled = clamp16(longint'(acc >>> FRAC_BITS));
  b      = bias;
  return clamp16(longint'(scaled) + longint'(b));
endfunction

function automatic logic [31:0] expected_word(int ox, int oy);
  logic [31:0] bias;
  bias = ref_mem[B_BASE];
  return {output_half(window_sum(ox, oy, 0), bias[31:16]),
          output_half(window_sum(ox, oy, 1), bias[15:0])};
endfunction

`endif

//--- tb/conv_tb.sv
`timescale 1ns/1ps

module conv_tb;
  import conv_pkg::*;

  localparam int IMG_W      = 12;
  localparam int IMG_H      = 8;
  localparam int KERNEL     = 5;
  localparam int ADDR_W     = 16;
  localparam int W_BASE     = 'h0100;
  localparam int B_BASE     = 'h0140;
  localparam int OUT_BASE   = 'h0200;
  localparam int NTAP       = KERNEL * KERNEL;
  localparam int OUT_W      = IMG_W - KERNEL + 1;
  localparam int OUT_H      = IMG_H - KERNEL + 1;
  localparam int NOUT       = OUT_W * OUT_H;
  localparam int MEM_WORDS  = 1024;
  localparam int NUM_RUNS   = 4;
  localparam int CLK_PERIOD = 4;
  // coefficient load, fill and step slots per row, drain, done, start
  localparam int FRAME_CYCLES = 2 * NTAP + 1
    + OUT_H * ((KERNEL - 1) * (KERNEL + 1) + OUT_W * (KERNEL + 2)) + KERNEL + 4;

  logic              clk;
  logic              rst;
  logic              start;
  pair_t             mem_rdata = '0;
  logic [ADDR_W-1:0] mem_addr;
  logic              mem_wen;
  pair_t             mem_wdata;
  logic              done;

  logic [31:0] mem     [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];
  logic        mem_load;
  logic        stats_clear;
  logic        busy;
  logic [15:0] lfsr;
  int          write_count;
  int          hit [NOUT];
  int          mon_errors = 0;
  int          errors;
  int          tests_run;
  int          tests_failed;

  `include "conv_ref_model.svh"

  conv_top #(
    .IMG_W    (IMG_W),
    .IMG_H    (IMG_H),
    .KERNEL   (KERNEL),
    .ADDR_W   (ADDR_W),
    .W_BASE   (W_BASE),
    .B_BASE   (B_BASE),
    .OUT_BASE (OUT_BASE)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .mem_wen   (mem_wen),
    .mem_wdata (mem_wdata),
    .done      (done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // single-port memory with one cycle of read latency
  always @(posedge clk) begin
    if (mem_load) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= ref_mem[i];
      end
    end else if (mem_wen) begin
      mem[mem_addr[9:0]] <= mem_wdata;
    end
    mem_rdata <= mem[mem_addr[9:0]];
  end

  // write and idle monitor
  always @(negedge clk) begin
    int waddr;
    waddr = int'(mem_addr) - OUT_BASE;
    if (stats_clear) begin
      write_count <= 0;
      for (int i = 0; i < NOUT; i++) begin
        hit[i] <= 0;
      end
    end else if (mem_wen) begin
      write_count <= write_count + 1;
      assert (waddr >= 0 && waddr < NOUT) else begin
        $display("write to address %h outside the output region", mem_addr);
        mon_errors++;
      end
      if (waddr >= 0 && waddr < NOUT) begin
        hit[waddr] <= hit[waddr] + 1;
      end
    end
    assert (busy && !rst || (!mem_wen && !done)) else begin
      $display("mem_wen or done high during reset or while idle at %0t", $time);
      mon_errors++;
    end
  end

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [15:0] draw_bits(int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [15:0] rand_signed(int n);
    logic [15:0] v;
    v = draw_bits(n);
    if (v[n-1]) begin
      v = v | (16'hffff << n);
    end
    return v;
  endfunction

  // kind 0 small random, 1 drives the rescale past range, 2 extreme bias
  task automatic fill_frame(input int kind);
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = {6'h2a, i[9:0], ~i[15:0]};
    end
    for (int i = 0; i < IMG_W * IMG_H; i++) begin
      case (kind)
        1:       ref_mem[i] = {16'h1000 | draw_bits(12), 16'h1000 | draw_bits(12)};
        2:       ref_mem[i] = {16'd16 + draw_bits(8), 16'd16 + draw_bits(8)};
        default: ref_mem[i] = {rand_signed(10), rand_signed(10)};
      endcase
    end
    for (int t = 0; t < NTAP; t++) begin
      case (kind)
        1: begin
          ref_mem[W_BASE + t]        = {16'h0400 | draw_bits(8), 16'h0400 | draw_bits(8)};
          ref_mem[W_BASE + NTAP + t] = {-(16'h0400 | draw_bits(8)),
                                        -(16'h0400 | draw_bits(8))};
        end
        2: begin
          ref_mem[W_BASE + t]        = {16'd1 + draw_bits(4), 16'd1 + draw_bits(4)};
          ref_mem[W_BASE + NTAP + t] = {-(16'd1 + draw_bits(4)), -(16'd1 + draw_bits(4))};
        end
        default: begin
          ref_mem[W_BASE + t]        = {rand_signed(6), rand_signed(6)};
          ref_mem[W_BASE + NTAP + t] = {rand_signed(6), rand_signed(6)};
        end
      endcase
    end
    case (kind)
      1:       ref_mem[B_BASE] = '0;
      2:       ref_mem[B_BASE] = {PIX_MAX, PIX_MIN};
      default: ref_mem[B_BASE] = {rand_signed(12), rand_signed(12)};
    endcase
  endtask

  task automatic run_frame(input string name, input int kind);
    int          waited;
    int          err0;
    int          sat_max;
    int          sat_min;
    logic [31:0] got;
    logic [31:0] exp_word;
    err0    = errors + mon_errors;
    sat_max = 0;
    sat_min = 0;
    fill_frame(kind);
    @(posedge clk);
    mem_load    <= 1'b1;
    stats_clear <= 1'b1;
    @(posedge clk);
    mem_load    <= 1'b0;
    stats_clear <= 1'b0;
    start       <= 1'b1;
    busy = 1'b1;
    @(posedge clk);
    start <= 1'b0;
    waited = 0;
    while (!done && waited < 2 * FRAME_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    // the idle monitor takes over from the cycle after done
    busy <= 1'b0;
    assert (done) else begin
      $display("test %s: done did not arrive within %0d cycles", name, waited);
      errors++;
    end
    assert (write_count == NOUT) else begin
      $display("MISMATCH t=%0t test %s: %0d writes before done, expected %0d",
               $time, name, write_count, NOUT);
      errors++;
    end
    @(negedge clk);
    assert (!done) else begin
      $display("test %s: done stayed high for more than one cycle", name);
      errors++;
    end
    for (int oy = 0; oy < OUT_H; oy++) begin
      for (int ox = 0; ox < OUT_W; ox++) begin
        got      = mem[OUT_BASE + oy * OUT_W + ox];
        exp_word = expected_word(ox, oy);
        assert (got === exp_word) else begin
          $display("MISMATCH t=%0t output (%0d,%0d): got %h expected %h",
                   $time, ox, oy, got, exp_word);
          errors++;
        end
        sat_max += (got[31:16] == PIX_MAX) ? 1 : 0;
        sat_min += (got[15:0] == PIX_MIN) ? 1 : 0;
      end
    end
    for (int i = 0; i < NOUT; i++) begin
      assert (hit[i] == 1) else begin
        $display("MISMATCH t=%0t test %s: output word %0d written %0d times, expected 1",
                 $time, name, i, hit[i]);
        errors++;
      end
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (i < OUT_BASE || i >= OUT_BASE + NOUT) begin
        assert (mem[i] === ref_mem[i]) else begin
          $display("MISMATCH t=%0t test %s: input word at %h is %h, expected %h",
                   $time, name, i, mem[i], ref_mem[i]);
          errors++;
        end
      end
    end
    if (kind != 0) begin
      assert (sat_max == NOUT && sat_min == NOUT) else begin
        $display("MISMATCH t=%0t test %s: %0d/%0d outputs saturated high and %0d/%0d low",
                 $time, name, sat_max, NOUT, sat_min, NOUT);
        errors++;
      end
    end
    tests_run++;
    if (errors + mon_errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors + mon_errors - err0);
    end
  endtask

  initial begin
    rst          = 1'b1;
    start        = 1'b0;
    mem_load     = 1'b0;
    stats_clear  = 1'b0;
    busy         = 1'b0;
    lfsr         = 16'd20731;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    run_frame("random", 0);
    run_frame("rescale_saturation", 1);
    run_frame("bias_saturation", 2);
    run_frame("restart_random", 0);
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors + mon_errors);
    if (errors + mon_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // room for every frame to hit its own timeout first
  initial begin
    #(CLK_PERIOD * (NUM_RUNS * 3 * FRAME_CYCLES + 100));
    $display("watchdog expired before the last test finished");
    $display("Simulation failed");
    $finish;
  end

endmodule
